// ==== pio_consts.svh ====
/* Widths and instruction encodings shared by the PIO state machine.
   Included by every RTL file and by the package. */
`ifndef PIO_CONSTS_SVH
`define PIO_CONSTS_SVH

`define PIO_INSTR_W      16
`define PIO_PROG_DEPTH   32
`define PIO_PC_W         5
`define PIO_DATA_W       32
`define PIO_SHIFT_CNT_W  6

`define PIO_OP_JMP       3'd0
`define PIO_OP_IN        3'd2
`define PIO_OP_OUT       3'd3
`define PIO_OP_PUSH_PULL 3'd4   // PUSH and PULL share one code
`define PIO_OP_MOV       3'd5
`define PIO_OP_SET       3'd7

`define PIO_SRC_PINS     3'd0
`define PIO_SRC_X        3'd1
`define PIO_SRC_Y        3'd2
`define PIO_SRC_NULL     3'd3
`define PIO_SRC_PINDIRS  3'd4   // SET and OUT only
`define PIO_SRC_ISR      3'd6
`define PIO_SRC_OSR      3'd7

`endif

// ==== pio_pkg.sv ====
/* Types of the PIO machine: the instruction word and its views, the
   configuration structs and the control bundle from the executor. */
`include "pio_consts.svh"

package pio_pkg;

  typedef enum logic [2:0] {
    OP_JMP       = `PIO_OP_JMP,
    OP_IN        = `PIO_OP_IN,
    OP_OUT       = `PIO_OP_OUT,
    OP_PUSH_PULL = `PIO_OP_PUSH_PULL,
    OP_MOV       = `PIO_OP_MOV,
    OP_SET       = `PIO_OP_SET
  } pio_opcode_e;

  typedef struct packed {
    pio_opcode_e op;
    logic [4:0]  delay;
    logic [2:0]  a;
    logic [4:0]  b;
  } pio_common_t;

  typedef struct packed {
    logic [7:0] head;        // Opcode and delay
    logic [2:0] cond;
    logic [4:0] addr;
  } pio_jmp_t;

  typedef struct packed {
    logic [7:0] head;
    logic [2:0] dst;
    logic [1:0] op;          // None, invert, bit-reverse
    logic [2:0] src;
  } pio_mov_t;

  typedef struct packed {
    logic [7:0] head;
    logic [2:0] sel;         // IN source or OUT destination
    logic [4:0] count;       // Zero stands for 32
  } pio_shift_t;

  typedef struct packed {
    logic [7:0] head;
    logic       pull;
    logic       if_cond;
    logic       block;
    logic [4:0] rsvd;
  } pio_pushpull_t;

  typedef union packed {
    pio_common_t   c;
    pio_jmp_t      jmp;
    pio_mov_t      mov;
    pio_shift_t    shift;
    pio_pushpull_t pp;
  } pio_instr_u;

  typedef struct packed {
    logic [4:0] set_base;
    logic [2:0] set_count;
    logic [4:0] out_base;
    logic [5:0] out_count;
    logic [4:0] in_base;
  } pio_pin_cfg_t;

  typedef struct packed {
    logic in_right;
    logic out_right;
  } pio_shift_cfg_t;

  typedef struct packed {
    logic [`PIO_PC_W-1:0] wrap_top;
    logic [`PIO_PC_W-1:0] wrap_target;
  } pio_wrap_t;

  typedef struct packed {
    logic                        jmp;
    logic [`PIO_PC_W-1:0]        new_pc;
    logic                        set_pins;
    logic                        set_dirs;
    logic                        out_pins;
    logic                        out_dirs;
    logic [`PIO_DATA_W-1:0]      pin_value;
    logic                        isr_load;
    logic                        isr_shift;
    logic [`PIO_DATA_W-1:0]      isr_value;
    logic                        osr_load;
    logic                        osr_shift;
    logic [`PIO_DATA_W-1:0]      osr_value;
    logic [`PIO_SHIFT_CNT_W-1:0] shift_count;
  } pio_ctl_t;

endpackage

// ==== pio_clock_divider.sv ====
/* Integer clock divider. Produces a one-clock execution tick every
   div_int clocks while the machine is enabled. */
`timescale 1ns/1ps
`include "pio_consts.svh"

module pio_clock_divider (
  input  logic        clk,
  input  logic        reset,
  input  logic        en,
  input  logic [15:0] div_int,
  output logic        tick
);

  logic [15:0] count;
  logic [15:0] reload;

  assign reload = (div_int > 16'd1) ? div_int - 16'd1 : '0;  // 0 acts as 1
  assign tick   = en && (count == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (en) begin
      count <= (count == '0) ? reload : count - 16'd1;  // Wraps to reload
    end
  end

  a_tick_needs_en: assert property (@(posedge clk) disable iff (reset) !en |-> !tick);

endmodule

// ==== pio_sequencer.sv ====
/* Program memory, program counter with wrap and the per-instruction
   delay counter. Presents the current instruction to the executor. */
`timescale 1ns/1ps
`include "pio_consts.svh"

module pio_sequencer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    tick,
  input  logic                    stall,
  input  logic                    jmp,
  input  logic [`PIO_PC_W-1:0]    new_pc,
  input  pio_pkg::pio_wrap_t      wrap,
  input  logic                    prog_we,
  input  logic [`PIO_PC_W-1:0]    prog_addr,
  input  logic [`PIO_INSTR_W-1:0] prog_data,
  output pio_pkg::pio_instr_u     instr,
  output logic                    busy,
  output logic [`PIO_PC_W-1:0]    pc
);
  import pio_pkg::*;

  logic [`PIO_INSTR_W-1:0] mem [`PIO_PROG_DEPTH];
  logic [`PIO_PC_W-1:0]    pc_next;
  logic [4:0]              delay_cnt;
  logic                    advance;

  assign busy    = (delay_cnt != '0);
  assign advance = tick && !stall && !busy;  // Current instruction completes

  always_comb begin
    if (reset) begin
      pc_next = '0;
    end else if (!advance) begin
      pc_next = pc;
    end else if (jmp) begin
      pc_next = new_pc;
    end else if (pc == wrap.wrap_top) begin
      pc_next = wrap.wrap_target;
    end else begin
      pc_next = pc + 1'b1;
    end
  end

  // Registered read of the next pc
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
    instr <= mem[pc_next];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= '0;
      delay_cnt <= '0;
    end else begin
      pc <= pc_next;
      if (advance) begin
        delay_cnt <= instr.c.delay;  // Delay of the finished instruction
      end else if (tick && busy) begin
        delay_cnt <= delay_cnt - 1'b1;
      end
    end
  end

  a_no_write_running: assert property (@(posedge clk) disable iff (reset)
    prog_we |-> !tick);

endmodule

// ==== pio_executor.sv ====
/* Combinational instruction decode. Holds X and Y and turns each executed
   instruction into the control bundle and the FIFO push and pull pulses. */
`timescale 1ns/1ps
`include "pio_consts.svh"

module pio_executor (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        tick,
  input  logic                        busy,
  input  pio_pkg::pio_instr_u         instr,
  input  logic [`PIO_DATA_W-1:0]      input_pins,
  input  pio_pkg::pio_pin_cfg_t       pin_cfg,
  input  pio_pkg::pio_shift_cfg_t     shift_cfg,
  input  logic [`PIO_DATA_W-1:0]      isr,
  input  logic [`PIO_DATA_W-1:0]      osr,
  input  logic [`PIO_SHIFT_CNT_W-1:0] isr_count,
  input  logic [`PIO_SHIFT_CNT_W-1:0] osr_count,
  input  logic [`PIO_DATA_W-1:0]      din,
  input  logic                        empty,
  input  logic                        full,
  output pio_pkg::pio_ctl_t           ctl,
  output logic                        stall,
  output logic                        push,
  output logic                        pull
);
  import pio_pkg::*;

  logic                        go;
  logic                        cond;
  logic [`PIO_DATA_W-1:0]      x, y, x_next, y_next;
  logic [2*`PIO_DATA_W-1:0]    pins_dbl;
  logic [`PIO_DATA_W-1:0]      in_pins, in_src, mov_src, mov_val, out_data;
  logic [`PIO_DATA_W:0]        mask_wide;
  logic [`PIO_SHIFT_CNT_W-1:0] nbits;

  function automatic logic [31:0] pick(input logic [2:0] sel, input logic [31:0] p,
                                       input logic [31:0] xv, input logic [31:0] yv,
                                       input logic [31:0] iv, input logic [31:0] ov);
    case (sel)
      `PIO_SRC_PINS: return p;
      `PIO_SRC_X:    return xv;
      `PIO_SRC_Y:    return yv;
      `PIO_SRC_ISR:  return iv;
      `PIO_SRC_OSR:  return ov;
      default:       return '0;  // NULL
    endcase
  endfunction

  assign go       = tick && !busy;
  assign pins_dbl = {input_pins, input_pins} >> pin_cfg.in_base;
  assign in_pins  = pins_dbl[`PIO_DATA_W-1:0];  // Rotated by in_base
  assign in_src   = pick(instr.shift.sel, in_pins, x, y, isr, osr);
  assign mov_src  = pick(instr.mov.src, in_pins, x, y, isr, osr);

  assign nbits     = (instr.shift.count == '0) ? 6'd32 : {1'b0, instr.shift.count};
  assign mask_wide = (33'd1 << nbits) - 33'd1;
  // Bits leaving the OSR, taken before the shift
  assign out_data  = shift_cfg.out_right ? (osr & mask_wide[`PIO_DATA_W-1:0])
                                         : (osr >> (6'd32 - nbits));

  always_comb begin
    case (instr.mov.op)
      2'd1:    mov_val = ~mov_src;
      2'd2:    mov_val = {<<{mov_src}};
      default: mov_val = mov_src;
    endcase
  end

  always_comb begin
    case (instr.jmp.cond)
      3'd0:    cond = 1'b1;
      3'd1:    cond = (x == '0);
      3'd2:    cond = (x != '0);  // Tested before the decrement
      3'd3:    cond = (y == '0);
      3'd4:    cond = (y != '0);
      3'd5:    cond = (x != y);
      3'd7:    cond = (osr_count < 6'd32);
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    ctl             = '0;
    stall           = 1'b0;
    push            = 1'b0;
    pull            = 1'b0;
    x_next          = x;
    y_next          = y;
    ctl.new_pc      = instr.jmp.addr;
    ctl.shift_count = nbits;
    if (go) begin
      case (instr.c.op)
        OP_JMP: begin
          ctl.jmp = cond;
          if (instr.jmp.cond == 3'd2) x_next = x - 1'b1;
          if (instr.jmp.cond == 3'd4) y_next = y - 1'b1;
        end
        OP_SET: begin
          ctl.pin_value = {27'd0, instr.c.b};
          case (instr.c.a)
            `PIO_SRC_PINS:    ctl.set_pins = 1'b1;
            `PIO_SRC_X:       x_next = {27'd0, instr.c.b};
            `PIO_SRC_Y:       y_next = {27'd0, instr.c.b};
            `PIO_SRC_PINDIRS: ctl.set_dirs = 1'b1;
            default: ;
          endcase
        end
        OP_MOV: begin
          ctl.pin_value = mov_val;
          ctl.isr_value = mov_val;
          ctl.osr_value = mov_val;
          case (instr.mov.dst)
            `PIO_SRC_PINS: ctl.out_pins = 1'b1;  // Uses the OUT window
            `PIO_SRC_X:    x_next = mov_val;
            `PIO_SRC_Y:    y_next = mov_val;
            `PIO_SRC_ISR:  ctl.isr_load = 1'b1;
            `PIO_SRC_OSR:  ctl.osr_load = 1'b1;
            default: ;
          endcase
        end
        OP_IN: begin
          ctl.isr_shift = 1'b1;
          ctl.isr_value = in_src;
        end
        OP_OUT: begin
          ctl.osr_shift = 1'b1;
          ctl.pin_value = out_data;
          ctl.isr_value = out_data;
          case (instr.shift.sel)
            `PIO_SRC_PINS:    ctl.out_pins = 1'b1;
            `PIO_SRC_X:       x_next = out_data;
            `PIO_SRC_Y:       y_next = out_data;
            `PIO_SRC_PINDIRS: ctl.out_dirs = 1'b1;
            `PIO_SRC_ISR:     ctl.isr_load = 1'b1;
            default: ;
          endcase
        end
        OP_PUSH_PULL: begin
          if (!instr.pp.pull) begin
            if (full && instr.pp.block) begin
              stall = 1'b1;
            end else begin
              push         = !full;  // Word dropped when full
              ctl.isr_load = 1'b1;   // Clears the ISR
            end
          end else if (!empty) begin
            pull          = 1'b1;
            ctl.osr_load  = 1'b1;
            ctl.osr_value = din;
          end else if (instr.pp.block) begin
            stall = 1'b1;
          end else begin
            ctl.osr_load  = 1'b1;    // Empty FIFO, X goes to the OSR
            ctl.osr_value = x;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else begin
      x <= x_next;
      y <= y_next;
    end
  end

  a_push_not_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);
  // The ISR restarts empty after every push
  a_push_clears_isr: assert property (@(posedge clk) disable iff (reset)
    push |=> isr_count == '0);

endmodule

// ==== pio_shift_in.sv ====
/* Input shift register. Shifts IN data left or right by the bit count,
   or loads a whole word from MOV, OUT or the clear on PUSH. */
`timescale 1ns/1ps
`include "pio_consts.svh"

module pio_shift_in (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        tick,
  input  pio_pkg::pio_ctl_t           ctl,
  input  pio_pkg::pio_shift_cfg_t     shift_cfg,
  output logic [`PIO_DATA_W-1:0]      isr,
  output logic [`PIO_SHIFT_CNT_W-1:0] isr_count
);
  import pio_pkg::*;

  logic [2*`PIO_DATA_W-1:0] right_cat, left_cat;
  logic [`PIO_SHIFT_CNT_W:0] count_sum;

  // New bits enter at the top for right shifts, at the bottom for left
  assign right_cat = {ctl.isr_value, isr} >> ctl.shift_count;
  assign left_cat  = {isr, ctl.isr_value << (6'd32 - ctl.shift_count)} << ctl.shift_count;
  assign count_sum = isr_count + ctl.shift_count;

  always_ff @(posedge clk) begin
    if (reset) begin
      isr       <= '0;
      isr_count <= '0;
    end else if (tick) begin
      if (ctl.isr_load) begin
        isr       <= ctl.isr_value;
        isr_count <= '0;
      end else if (ctl.isr_shift) begin
        isr       <= shift_cfg.in_right ? right_cat[`PIO_DATA_W-1:0]
                                        : left_cat[2*`PIO_DATA_W-1:`PIO_DATA_W];
        isr_count <= (count_sum > 7'd32) ? 6'd32 : count_sum[`PIO_SHIFT_CNT_W-1:0];
      end
    end
  end

endmodule

// ==== pio_shift_out.sv ====
/* Output shift register. Loads from the TX FIFO, from X or from MOV, and
   shifts out by the bit count while the count of used bits grows. */
`timescale 1ns/1ps
`include "pio_consts.svh"

module pio_shift_out (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        tick,
  input  pio_pkg::pio_ctl_t           ctl,
  input  pio_pkg::pio_shift_cfg_t     shift_cfg,
  output logic [`PIO_DATA_W-1:0]      osr,
  output logic [`PIO_SHIFT_CNT_W-1:0] osr_count
);
  import pio_pkg::*;

  logic [2*`PIO_DATA_W-1:0]  shifted;
  logic [`PIO_SHIFT_CNT_W:0] count_sum;

  assign shifted   = shift_cfg.out_right ? ({32'd0, osr} >> ctl.shift_count)
                                         : ({32'd0, osr} << ctl.shift_count);
  assign count_sum = osr_count + ctl.shift_count;

  always_ff @(posedge clk) begin
    if (reset) begin
      osr       <= '0;
      osr_count <= 6'd32;  // Empty until the first load
    end else if (tick) begin
      if (ctl.osr_load) begin
        osr       <= ctl.osr_value;
        osr_count <= '0;
      end else if (ctl.osr_shift) begin
        osr       <= shifted[`PIO_DATA_W-1:0];
        osr_count <= (count_sum > 7'd32) ? 6'd32 : count_sum[`PIO_SHIFT_CNT_W-1:0];
      end
    end
  end

  a_load_or_shift: assert property (@(posedge clk) disable iff (reset)
    !(ctl.osr_load && ctl.osr_shift));

endmodule

// ==== pio_pin_mapper.sv ====
/* Output pin and direction registers. SET and OUT values land in their
   base and count window, wrapping past pin 31; strobes mark pins written. */
`timescale 1ns/1ps
`include "pio_consts.svh"

module pio_pin_mapper (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   tick,
  input  pio_pkg::pio_ctl_t      ctl,
  input  pio_pkg::pio_pin_cfg_t  pin_cfg,
  output logic [`PIO_DATA_W-1:0] output_pins,
  output logic [`PIO_DATA_W-1:0] pin_directions,
  output logic [`PIO_DATA_W-1:0] output_pins_stb
);
  import pio_pkg::*;

  logic                   use_set, wr_pins, wr_dirs;
  logic [4:0]             base;
  logic [`PIO_DATA_W-1:0] win, val;

  function automatic logic [31:0] rotl(input logic [31:0] v, input logic [4:0] s);
    logic [63:0] d;
    d = {v, v} << s;
    return d[63:32];
  endfunction

  function automatic logic [31:0] low_mask(input logic [5:0] n);
    logic [32:0] m;
    m = (33'd1 << n) - 33'd1;
    return m[31:0];
  endfunction

  assign use_set = ctl.set_pins || ctl.set_dirs;
  assign base    = use_set ? pin_cfg.set_base : pin_cfg.out_base;
  assign win     = use_set ? rotl(low_mask({3'd0, pin_cfg.set_count}), base)
                           : rotl(low_mask(pin_cfg.out_count), base);
  assign val     = rotl(ctl.pin_value, base);  // Bit i to pin base+i
  assign wr_pins = tick && (ctl.set_pins || ctl.out_pins);
  assign wr_dirs = tick && (ctl.set_dirs || ctl.out_dirs);

  always_ff @(posedge clk) begin
    if (reset) begin
      output_pins     <= '0;
      pin_directions  <= '0;
      output_pins_stb <= '0;
    end else begin
      if (wr_pins) begin
        output_pins <= (output_pins & ~win) | (val & win);
      end
      if (wr_dirs) begin
        pin_directions <= (pin_directions & ~win) | (val & win);
      end
      output_pins_stb <= (wr_pins || wr_dirs) ? win : '0;  // One clock only
    end
  end

endmodule

// ==== pio_machine.sv ====
/* Top level of one PIO state machine. Connects divider, sequencer,
   executor, shift registers and pin mapper; FIFOs stay outside. */
`timescale 1ns/1ps
`include "pio_consts.svh"

module pio_machine (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    en,
  input  logic [15:0]             div_int,
  input  pio_pkg::pio_wrap_t      wrap,
  input  pio_pkg::pio_pin_cfg_t   pin_cfg,
  input  pio_pkg::pio_shift_cfg_t shift_cfg,
  input  logic                    prog_we,
  input  logic [`PIO_PC_W-1:0]    prog_addr,
  input  logic [`PIO_INSTR_W-1:0] prog_data,
  input  logic [`PIO_DATA_W-1:0]  input_pins,
  input  logic [`PIO_DATA_W-1:0]  din,
  input  logic                    empty,
  input  logic                    full,
  output logic [`PIO_PC_W-1:0]    pc,
  output logic                    push,
  output logic                    pull,
  output logic [`PIO_DATA_W-1:0]  dout,
  output logic [`PIO_DATA_W-1:0]  output_pins,
  output logic [`PIO_DATA_W-1:0]  pin_directions,
  output logic [`PIO_DATA_W-1:0]  output_pins_stb
);
  import pio_pkg::*;

  logic                        tick, busy, stall;
  pio_instr_u                  instr;
  pio_ctl_t                    ctl;
  logic [`PIO_DATA_W-1:0]      osr;
  logic [`PIO_SHIFT_CNT_W-1:0] isr_count, osr_count;

  pio_clock_divider u_div (
    .clk(clk), .reset(reset), .en(en), .div_int(div_int), .tick(tick)
  );

  pio_sequencer u_seq (
    .clk(clk), .reset(reset), .tick(tick), .stall(stall), .jmp(ctl.jmp),
    .new_pc(ctl.new_pc), .wrap(wrap), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .instr(instr), .busy(busy), .pc(pc)
  );

  pio_executor u_exec (
    .clk(clk), .reset(reset), .tick(tick), .busy(busy), .instr(instr),
    .input_pins(input_pins), .pin_cfg(pin_cfg), .shift_cfg(shift_cfg),
    .isr(dout), .osr(osr), .isr_count(isr_count), .osr_count(osr_count),
    .din(din), .empty(empty), .full(full),
    .ctl(ctl), .stall(stall), .push(push), .pull(pull)
  );

  // The ISR word is the RX FIFO data
  pio_shift_in u_isr (
    .clk(clk), .reset(reset), .tick(tick), .ctl(ctl), .shift_cfg(shift_cfg),
    .isr(dout), .isr_count(isr_count)
  );

  pio_shift_out u_osr (
    .clk(clk), .reset(reset), .tick(tick), .ctl(ctl), .shift_cfg(shift_cfg),
    .osr(osr), .osr_count(osr_count)
  );

  pio_pin_mapper u_pins (
    .clk(clk), .reset(reset), .tick(tick), .ctl(ctl), .pin_cfg(pin_cfg),
    .output_pins(output_pins), .pin_directions(pin_directions),
    .output_pins_stb(output_pins_stb)
  );

endmodule

// ==== tb_pio_machine.sv ====
/* Testbench for the PIO machine. Reads programs, configuration, TX words and
   expected results from the stim file and models the TX and RX FIFOs. */
`timescale 1ns/1ps

module tb_pio_machine;

  localparam int TIMEOUT = 500;  // Cycles per wait loop

  logic        clk = 1'b0;
  logic        reset, en, prog_we, empty, full, push, pull;
  logic [15:0] div_int;
  logic [9:0]  wrap;
  logic [23:0] pin_cfg;
  logic [1:0]  shift_cfg;
  logic [4:0]  prog_addr, pc;
  logic [15:0] prog_data;
  logic [31:0] input_pins, din, dout, output_pins, pin_directions, output_pins_stb;

  logic [31:0] tx_q[$];
  logic [31:0] rx_q[$];
  logic        pop_pending = 1'b0;
  logic        push_seen = 1'b0;
  logic        gap_mode = 1'b0;
  logic        start_gap = 1'b0;
  int          full_cnt = 0;

  pio_machine DUT (
    .clk(clk), .reset(reset), .en(en), .div_int(div_int), .wrap(wrap),
    .pin_cfg(pin_cfg), .shift_cfg(shift_cfg), .prog_we(prog_we),
    .prog_addr(prog_addr), .prog_data(prog_data), .input_pins(input_pins),
    .din(din), .empty(empty), .full(full), .pc(pc), .push(push), .pull(pull),
    .dout(dout), .output_pins(output_pins), .pin_directions(pin_directions),
    .output_pins_stb(output_pins_stb)
  );

  always #10 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  // Pins (base + i) mod 32 for every i below count
  function automatic logic [31:0] window_mask(input logic [4:0] base, input int count);
    logic [31:0] m;
    m = '0;
    for (int i = 0; i < count; i++) begin
      m[(base + i) % 32] = 1'b1;
    end
    return m;
  endfunction

  // RX FIFO model and pull detection
  always @(negedge clk) begin
    if (!reset && push) begin
      if (full) abort_run("Push pulse seen while the RX FIFO was full");
      rx_q.push_back(dout);
      push_seen = 1'b1;
    end
    if (!reset && pull) begin
      if (empty) abort_run("Pull pulse seen while the TX FIFO was empty");
      pop_pending = 1'b1;
    end
  end

  // TX FIFO model and full gaps, driven after the rising edge
  always @(posedge clk) begin
    #1;
    if (pop_pending) begin
      void'(tx_q.pop_front());
      pop_pending = 1'b0;
    end
    if (push_seen && gap_mode) full_cnt = $urandom_range(8, 1);
    push_seen = 1'b0;
    if (start_gap) begin
      full_cnt  = $urandom_range(10, 3);
      start_gap = 1'b0;
    end
    full = (full_cnt != 0);
    if (full_cnt != 0) full_cnt--;
    empty = (tx_q.size() == 0);
    din   = empty ? 32'd0 : tx_q[0];
  end

  task automatic write_word(input logic [4:0] addr, input logic [15:0] data);
    @(posedge clk);
    #1;
    prog_we   = 1'b1;
    prog_addr = addr;
    prog_data = data;
    @(posedge clk);
    #1;
    prog_we = 1'b0;
  endtask

  task automatic wait_strobe(input string what);
    int          n;
    logic [31:0] set_win, out_win;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (output_pins_stb == '0 && n < TIMEOUT);
    if (output_pins_stb == '0) abort_run({"Timeout waiting for a strobe on ", what});
    set_win = window_mask(pin_cfg[23:19], pin_cfg[18:16]);  // SET window
    out_win = window_mask(pin_cfg[15:11], pin_cfg[10:5]);   // OUT window
    check("output_pins_stb", output_pins_stb,
          (output_pins_stb == set_win) ? set_win : out_win);
  endtask

  task automatic wait_push_word(input logic [31:0] exp);
    int n;
    n = 0;
    while (rx_q.size() == 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rx_q.size() == 0) abort_run("Timeout waiting for a pushed word");
    check("dout", rx_q.pop_front(), exp);
  endtask

  initial begin
    int          fd, code, arg_a, arg_b, arg_c, arg_d, arg_e, arg_f;
    logic [127:0] tok, kind;
    logic [8*200-1:0] line;
    logic [31:0] val;

    void'($urandom(32'h63f9cc63));
    reset      = 1'b1;
    en         = 1'b0;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    div_int    = 16'd1;
    wrap       = '0;
    pin_cfg    = '0;
    shift_cfg  = '0;
    input_pins = 32'h12345678;
    din        = '0;
    empty      = 1'b1;
    full       = 1'b0;
    fd = $fopen("tb_pio_stim.txt", "r");
    if (fd == 0) abort_run("Could not open the stim file");
    code = $fscanf(fd, "%s", tok);
    while (code == 1) begin
      if (tok == "#") begin
        code = $fgets(line, fd);  // Skip the comment text
      end else if (tok == "C") begin
        code = $fscanf(fd, "%h %h %h %h %h %h", arg_a, arg_b, arg_c, arg_d, arg_e, arg_f);
        @(posedge clk);
        #1;
        en    = 1'b0;
        reset = 1'b1;
        tx_q.delete();
        rx_q.delete();
        gap_mode = arg_f[0];
        full_cnt = 0;
        div_int  = (arg_a == 0) ? 16'($urandom_range(4, 1)) : 16'(arg_a);
        wrap      = {arg_b[4:0], arg_c[4:0]};
        pin_cfg   = arg_d[23:0];
        shift_cfg = arg_e[1:0];
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
      end else if (tok == "P") begin
        code = $fscanf(fd, "%h %h", arg_a, arg_b);
        write_word(arg_a[4:0], arg_b[15:0]);
      end else if (tok == "X") begin
        code = $fscanf(fd, "%h", val);
        tx_q.push_back(val);
      end else if (tok == "R") begin
        @(posedge clk);
        #1;
        en = 1'b1;
        if (gap_mode) start_gap = 1'b1;
      end else if (tok == "W") begin
        code = $fscanf(fd, "%d", arg_a);
        repeat (arg_a) @(negedge clk);
      end else if (tok == "E") begin
        code = $fscanf(fd, "%s %h", kind, val);
        if (kind == "p") begin
          wait_strobe("output_pins");
          check("output_pins", output_pins, val);
        end else if (kind == "d") begin
          wait_strobe("pin_directions");
          check("pin_directions", pin_directions, val);
        end else if (kind == "w") begin
          wait_push_word(val);
        end else begin
          check("pc", {27'd0, pc}, val);
        end
      end else if (tok == "D") begin
        check("extra pushed words", rx_q.size(), 32'd0);
      end else begin
        abort_run("Unknown record in the stim file");
      end
      code = $fscanf(fd, "%s", tok);
    end
    $fclose(fd);
    $display("No errors");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+.
pio_pkg.sv
pio_clock_divider.sv
pio_sequencer.sv
pio_executor.sv
pio_shift_in.sv
pio_shift_out.sv
pio_pin_mapper.sv
pio_machine.sv
tb_pio_machine.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the PIO machine testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_pio_machine -Mdir obj_dir
./obj_dir/Vtb_pio_machine

// ==== tb_pio_stim.txt ====
# C div wrap_top wrap_target pin_cfg shift_cfg full_gaps | P addr word | X tx_word
# R run | W cycles | E p/d/w/c value | D end of test (no extra pushes)
C 0 1f 00 f30400 0 0
P 00 a00b
P 01 e085
P 02 e006
P 03 0003
R
E p ffffffff
E d 40000001
E p bfffffff
D
C 0 03 04 010400 0 1
P 00 e023
P 01 a0c1
P 02 8020
P 03 0041
P 04 e001
P 05 0005
R
E w 00000003
E w 00000002
E w 00000001
E w 00000000
E p 00000001
D
C 0 1f 00 000100 1 0
P 00 80a0
P 01 6008
P 02 6008
P 03 6008
P 04 6008
P 05 0000
X 44332211
X 88776655
R
E p 00000011
E p 00000022
E p 00000033
E p 00000044
E p 00000055
E p 00000066
E p 00000077
E p 00000088
D
C 0 1f 00 000100 0 0
P 00 80a0
P 01 6008
P 02 6008
P 03 6008
P 04 6008
P 05 0000
X a1b2c3d4
R
E p 000000a1
E p 000000b2
E p 000000c3
E p 000000d4
D
C 0 1f 00 000004 0 0
P 00 e025
P 01 4024
P 02 4008
P 03 8020
P 04 0004
R
E w 00000567
D
C 0 1f 00 000000 0 0
P 00 e333
P 01 a049
P 02 a0c2
P 03 8020
P 04 a051
P 05 a0c2
P 06 8020
P 07 0007
R
E w ffffffec
E w c8000000
D
C 0 1f 00 000000 0 1
P 00 80a0
P 01 a0c7
P 02 8020
P 03 0000
R
W 20
E c 00000000
X cafef00d
E w cafef00d
X deadbeef
E w deadbeef
W 20
E c 00000000
D
